// File: project.f
+incdir+common
common/cacheLinePkg.sv
common/cacheBusPkg.sv
dataCache/lineSram.sv
dataCache/tagStore.sv
dataCache/dataCacheCtrl.sv
logic/dataCacheTop.sv
test/dataCache_asserts.sv
test/dataCacheTb.sv

// File: Makefile
TOP = dataCacheTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o simv
	./obj_dir/simv > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

// File: test/dataCacheTb.sv
// Testbench of the data cache with a memory arbiter model and a shadow memory
// Runs a table of core requests, checks data, latency and memory traffic per row
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dataCacheTb;
   import cacheLinePkg::*;
   import cacheBusPkg::*;

   // One stimulus row with an 8-character name
   typedef struct packed {
      logic [63:0]              name;
      logic                     write;
      logic [`DC_WORD_BITS-1:0] addr;
      logic [`DC_WORD_BITS-1:0] wrData;
      logic                     expHit;
      logic [3:0]               respHold;
   } rowT;

   localparam int numRows    = 10;
   localparam int cycleLimit = numRows * 60;

   // Line A at index 0, line B at index 2, line C evicts A
   rowT stimRows [numRows] = '{
      '{"rdMiss_A", 1'b0, 32'h0000_1004, 32'h0000_0000, 1'b0, 4'd0},
      '{"rdHit__A", 1'b0, 32'h0000_101c, 32'h0000_0000, 1'b1, 4'd0},
      '{"wrHit__A", 1'b1, 32'h0000_1008, 32'hcafe_0001, 1'b1, 4'd0},
      '{"rdHitNew", 1'b0, 32'h0000_1008, 32'h0000_0000, 1'b1, 4'd0},
      '{"wrMiss_B", 1'b1, 32'h0000_2044, 32'hbeef_0002, 1'b0, 4'd0},
      '{"rdHit__B", 1'b0, 32'h0000_2044, 32'h0000_0000, 1'b1, 4'd0},
      '{"rdEvictC", 1'b0, 32'h0000_3004, 32'h0000_0000, 1'b0, 4'd0},
      '{"rdEvictA", 1'b0, 32'h0000_1008, 32'h0000_0000, 1'b0, 4'd0},
      '{"bpHold_B", 1'b0, 32'h0000_2048, 32'h0000_0000, 1'b1, 4'd6},
      '{"bpNext_A", 1'b0, 32'h0000_1010, 32'h0000_0000, 1'b1, 4'd0}
   };

   logic     rwArbiterCacheBus;
   logic     rstN;
   coreReqT  coreReq;
   logic     reqAck;
   coreRespT coreResp;
   logic     respAck;
   memReqT   memReq;
   logic     memReqAck;
   memRespT  memResp;
   logic     memRespAck;

   // Backing store and the core's view of it by word address
   logic [31:0] memWords [logic [29:0]];
   logic [31:0] shadow [logic [29:0]];
   // Accepted memory beats of the current row as {write, payload}
   logic [32:0] beatLog [$];
   logic [32:0] pendingBeat;
   logic [29:0] refillWord;
   logic [29:0] writeWord;
   int          refillLeft = 0;
   int          writeLeft  = 0;
   int          ackWait    = 0;
   int          respWait   = 0;
   logic [31:0] rngState   = 32'had8a;
   int          errors     = 0;
   int          cycles     = 0;

   dataCacheTop uut (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .rstN              (rstN),
      .coreReq           (coreReq),
      .reqAck            (reqAck),
      .coreResp          (coreResp),
      .respAck           (respAck),
      .memReq            (memReq),
      .memReqAck         (memReqAck),
      .memResp           (memResp),
      .memRespAck        (memRespAck)
   );

   initial begin
      rwArbiterCacheBus = 1'b0;
      forever #10 rwArbiterCacheBus = ~rwArbiterCacheBus;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // 0 to 3 cycles of memory delay
   function automatic int randomDelay();
      rngState = xorshift32(rngState);
      return int'(rngState[1:0]);
   endfunction

   // Pattern for unwritten words uses every address bit
   function automatic logic [31:0] fillWord(input logic [29:0] w);
      return {w[13:0], 2'b01, w[29:14]} ^ 32'h5a3c_0f96;
   endfunction

   function automatic logic [31:0] memWord(input logic [29:0] w);
      return memWords.exists(w) ? memWords[w] : fillWord(w);
   endfunction

   function automatic logic [31:0] shadowWord(input logic [29:0] w);
      return shadow.exists(w) ? shadow[w] : fillWord(w);
   endfunction

   task automatic checkValue(input string tag, input logic [32:0] expected,
                             input logic [32:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("MISMATCH %s expected %0h actual %0h", tag, expected, actual);
      end
   endtask

   // Read address starts a refill; a write address opens an 8-beat burst
   task automatic takeBeat(input logic [32:0] beat);
      beatLog.push_back(beat);
      if (!beat[32]) begin
         refillWord = beat[31:2];
         refillLeft = 8;
         respWait   = randomDelay();
      end else if (writeLeft == 0) begin
         writeWord = beat[31:2];
         writeLeft = 8;
      end else begin
         memWords[writeWord] = beat[31:0];
         writeWord++;
         writeLeft--;
      end
   endtask

   // Arbiter model reacting to outputs settled after the edge
   always @(posedge rwArbiterCacheBus) begin
      #2;
      if (rstN) begin
         if (memReqAck) begin
            memReqAck = 1'b0;
            takeBeat(pendingBeat);
            ackWait = randomDelay();
         end else if (memReq.reqCyc) begin
            if (ackWait == 0) begin
               memReqAck   = 1'b1;
               pendingBeat = {memReq.write, memReq.payload};
            end else begin
               ackWait--;
            end
         end
         // Refill beats held until memRespAck
         if (memRespAck) begin
            memResp.respCyc = 1'b0;
            refillWord++;
            refillLeft--;
            respWait = randomDelay();
         end else if (refillLeft > 0 && !memResp.respCyc) begin
            if (respWait == 0) begin
               memResp.respCyc = 1'b1;
               memResp.rdData  = memWord(refillWord);
            end else begin
               respWait--;
            end
         end
      end
   end

   always @(posedge rwArbiterCacheBus) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("Timeout: cache did not finish the table within %0d cycles", cycleLimit);
         $display("TB FAILED");
         $finish;
      end
   end

   // Beat count, refill address, write-through line and backing word
   task automatic checkTraffic(input rowT row, input string nm);
      logic [29:0] word;
      logic [29:0] lineWord;
      int          expBeats;
      int          base;
      word     = row.addr[31:2];
      lineWord = {word[29:3], 3'b000};
      expBeats = row.write ? 9 : 0;
      if (!row.expHit) begin
         expBeats++;
      end
      checkValue({nm, " beats"}, 33'(expBeats), 33'(beatLog.size()));
      if (beatLog.size() == expBeats) begin
         base = row.expHit ? 0 : 1;
         if (!row.expHit) begin
            checkValue({nm, " refillAddr"}, {1'b0, lineWord, 2'b00}, beatLog[0]);
         end
         if (row.write) begin
            checkValue({nm, " writeAddr"}, {1'b1, lineWord, 2'b00}, beatLog[base]);
            for (int k = 0; k < 8; k++) begin
               checkValue({nm, " writeBeat"}, {1'b1, shadowWord(lineWord + 30'(k))},
                          beatLog[base + 1 + k]);
            end
            checkValue({nm, " memory"}, {1'b0, row.wrData}, {1'b0, memWord(word)});
         end
      end
   endtask

   task automatic runRow(input rowT row);
      string       nm;
      logic [29:0] word;
      logic [31:0] expData;
      logic [31:0] heldData;
      int          ackLat;
      int          lat;
      nm   = $sformatf("%s", row.name);
      word = row.addr[31:2];
      // Shadow takes the write as soon as it is issued
      if (row.write) begin
         shadow[word] = row.wrData;
      end
      expData = shadowWord(word);
      beatLog.delete();
      coreReq.reqCyc = 1'b1;
      coreReq.write  = row.write;
      coreReq.addr   = row.addr;
      coreReq.wrData = row.wrData;
      ackLat = 0;
      do begin
         @(posedge rwArbiterCacheBus);
         #2;
         ackLat++;
      end while (!reqAck);
      coreReq.reqCyc = 1'b0;
      // Request sampled in idle is acknowledged on the next cycle
      checkValue({nm, " reqAck"}, 33'(1), 33'(ackLat));
      lat = 0;
      do begin
         @(posedge rwArbiterCacheBus);
         #2;
         lat++;
      end while (!coreResp.respCyc);
      if (row.expHit && !row.write) begin
         checkValue({nm, " latency"}, 33'(2), 33'(lat));
      end
      if (!row.write) begin
         checkValue({nm, " rdData"}, {1'b0, expData}, {1'b0, coreResp.rdData});
      end
      // Response must sit still while respAck is late
      heldData = coreResp.rdData;
      repeat (row.respHold) begin
         @(posedge rwArbiterCacheBus);
         #2;
         if (!coreResp.respCyc || reqAck) begin
            errors++;
            $display("%s: response dropped or request taken while respAck was late", nm);
         end
         checkValue({nm, " held"}, {1'b0, heldData}, {1'b0, coreResp.rdData});
      end
      respAck = 1'b1;
      @(posedge rwArbiterCacheBus);
      #2;
      respAck = 1'b0;
      checkTraffic(row, nm);
   endtask

   initial begin
      rstN      = 1'b0;
      coreReq   = '0;
      respAck   = 1'b0;
      memReqAck = 1'b0;
      memResp   = '0;
      repeat (4) @(posedge rwArbiterCacheBus);
      #2;
      rstN = 1'b1;
      for (int r = 0; r < numRows; r++) begin
         runRow(stimRows[r]);
      end
      $display("Table done: %0d rows, %0d errors", numRows, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/dataCache_asserts.sv
// Concurrent checks on the core and memory handshakes of the cache controller
// Bound into dataCacheCtrl below, so no testbench wiring is needed
`timescale 1ns/1ps
`default_nettype none

module dataCacheAsserts (
   input logic                   rwArbiterCacheBus,
   input logic                   rstN,
   input logic                   reqAck,
   input cacheBusPkg::coreRespT  coreResp,
   input logic                   respAck,
   input cacheBusPkg::memReqT    memReq,
   input logic                   memReqAck,
   input logic                   memRespAck,
   input logic                   tagWrite,
   input cacheLinePkg::wordMaskT wordWrite
);

   // reqAck is a one-cycle pulse
   ackPulse: assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
      reqAck |=> !reqAck)
      else $error("reqAck held for more than one cycle");

   // Core response holds with its data until respAck
   respHold: assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
      coreResp.respCyc && !respAck |=> coreResp.respCyc && $stable(coreResp.rdData))
      else $error("core response changed before respAck");

   // Memory beat holds until memReqAck
   beatHold: assert property (@(posedge rwArbiterCacheBus) disable iff (!rstN)
      memReq.reqCyc && !memReqAck |=>
         memReq.reqCyc && $stable(memReq.write) && $stable(memReq.payload))
      else $error("memory beat changed before memReqAck");

   // Quiet outputs while reset is held
   resetQuiet: assert property (@(posedge rwArbiterCacheBus)
      !rstN |=> !reqAck && !coreResp.respCyc && !memReq.reqCyc && !memRespAck
         && !tagWrite && (wordWrite == '0))
      else $error("control output high during reset");

endmodule

bind dataCacheCtrl dataCacheAsserts handshakeChecks (
   .rwArbiterCacheBus (rwArbiterCacheBus),
   .rstN              (rstN),
   .reqAck            (reqAck),
   .coreResp          (coreResp),
   .respAck           (respAck),
   .memReq            (memReq),
   .memReqAck         (memReqAck),
   .memRespAck        (memRespAck),
   .tagWrite          (tagWrite),
   .wordWrite         (wordWrite)
);

`default_nettype wire

// File: logic/dataCacheTop.sv
// Data cache top level between the core and the memory arbiter
// Controller, tag store and line store share one index taken from the held request
`timescale 1ns/1ps
`default_nettype none

module dataCacheTop (
   input  logic                  rwArbiterCacheBus,
   input  logic                  rstN,
   input  cacheBusPkg::coreReqT  coreReq,
   output logic                  reqAck,
   output cacheBusPkg::coreRespT coreResp,
   input  logic                  respAck,
   output cacheBusPkg::memReqT   memReq,
   input  logic                  memReqAck,
   input  cacheBusPkg::memRespT  memResp,
   output logic                  memRespAck
);
   import cacheLinePkg::*;

   cacheAddrT lookupAddr;
   logic      hit;
   cacheLineT readLine;
   logic      tagWrite;
   cacheTagT  writeTag;
   cacheLineT writeLine;
   wordMaskT  wordWrite;

   dataCacheCtrl ctrl (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .rstN              (rstN),
      .coreReq           (coreReq),
      .reqAck            (reqAck),
      .coreResp          (coreResp),
      .respAck           (respAck),
      .memReq            (memReq),
      .memReqAck         (memReqAck),
      .memResp           (memResp),
      .memRespAck        (memRespAck),
      .lookupAddr        (lookupAddr),
      .hit               (hit),
      .readLine          (readLine),
      .tagWrite          (tagWrite),
      .writeTag          (writeTag),
      .writeLine         (writeLine),
      .wordWrite         (wordWrite)
   );

   // Writes land on the line being looked up
   tagStore tags (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .rstN              (rstN),
      .lookupAddr        (lookupAddr),
      .hit               (hit),
      .tagWrite          (tagWrite),
      .writeIndex        (lookupAddr.index),
      .writeTag          (writeTag)
   );

   lineSram lines (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .readIndex         (lookupAddr.index),
      .readLine          (readLine),
      .writeIndex        (lookupAddr.index),
      .writeLine         (writeLine),
      .wordWrite         (wordWrite)
   );

endmodule

`default_nettype wire

// File: dataCache/dataCacheCtrl.sv
// Data cache controller for the core handshake, lookup, refill and write-through
// One request in flight; writes allocate, merge one word and send the whole line
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dataCacheCtrl (
   input  logic                    rwArbiterCacheBus,
   input  logic                    rstN,
   input  cacheBusPkg::coreReqT    coreReq,
   output logic                    reqAck,
   output cacheBusPkg::coreRespT   coreResp,
   input  logic                    respAck,
   output cacheBusPkg::memReqT     memReq,
   input  logic                    memReqAck,
   input  cacheBusPkg::memRespT    memResp,
   output logic                    memRespAck,
   output cacheLinePkg::cacheAddrT lookupAddr,
   input  logic                    hit,
   input  cacheLinePkg::cacheLineT readLine,
   output logic                    tagWrite,
   output cacheLinePkg::cacheTagT  writeTag,
   output cacheLinePkg::cacheLineT writeLine,
   output cacheLinePkg::wordMaskT  wordWrite
);
   import cacheLinePkg::*;
   import cacheBusPkg::*;

   ctrlStateT                  state;
   coreReqT                    reqReg;
   cacheAddrT                  lineAddr;
   cacheLineT                  lineBuf;
   cacheLineT                  refillLine;
   cacheLineT                  hitLine;
   logic [`DC_OFFSET_BITS-1:0] beatCnt;
   logic [`DC_OFFSET_BITS-1:0] nextBeat;
   logic                       lookupReady;
   logic                       respCyc;
   logic [`DC_WORD_BITS-1:0]   respData;
   logic                       memReqCyc;
   logic                       memReqWrite;
   memPayloadU                 memPayload;
   logic                       beatIn;
   logic                       beatOut;

   // Line-aligned address for the first memory beat
   always_comb begin
      lineAddr         = reqReg.addr;
      lineAddr.offset  = '0;
      lineAddr.byteOff = '0;
   end

   // Line buffer with the arriving beat placed
   // Write data goes on top so the installed line is already merged
   always_comb begin
      refillLine          = lineBuf;
      refillLine[beatCnt] = memResp.rdData;
      if (reqReg.write) begin
         refillLine[reqReg.addr.offset] = reqReg.wrData;
      end
      hitLine                     = readLine;
      hitLine[reqReg.addr.offset] = reqReg.wrData;
   end

   // Refill beat taken only after the address beat is gone
   // and not again in the cycle the ack is still showing
   assign beatIn   = (state == refill) && !memReqCyc && memResp.respCyc && !memRespAck;
   assign beatOut  = memReqCyc && memReqAck;
   assign nextBeat = (state == writeAddr) ? '0 : beatCnt + 1'b1;

   always_ff @(posedge rwArbiterCacheBus) begin
      if (!rstN) begin
         state       <= idle;
         reqAck      <= 1'b0;
         respCyc     <= 1'b0;
         memReqCyc   <= 1'b0;
         memRespAck  <= 1'b0;
         tagWrite    <= 1'b0;
         wordWrite   <= '0;
         beatCnt     <= '0;
         lookupReady <= 1'b0;
      end else begin
         // Pulses by default
         reqAck     <= 1'b0;
         memRespAck <= beatIn;
         tagWrite   <= 1'b0;
         wordWrite  <= '0;
         case (state)
            idle: begin
               if (coreReq.reqCyc) begin
                  reqAck      <= 1'b1;
                  lookupReady <= 1'b0;
                  state       <= lookup;
               end
            end
            lookup: begin
               // First cycle presents the index, second sees the result
               lookupReady <= 1'b1;
               if (lookupReady) begin
                  if (!hit) begin
                     memReqCyc <= 1'b1;
                     beatCnt   <= '0;
                     state     <= refill;
                  end else if (reqReg.write) begin
                     wordWrite <= wordMaskT'(1) << reqReg.addr.offset;
                     memReqCyc <= 1'b1;
                     state     <= writeAddr;
                  end else begin
                     respCyc <= 1'b1;
                     state   <= respond;
                  end
               end
            end
            refill: begin
               if (beatOut) begin
                  memReqCyc <= 1'b0;
               end
               if (beatIn) begin
                  beatCnt <= beatCnt + 1'b1;
                  if (beatCnt == '1) begin
                     // Install line and tag next cycle from lineBuf
                     tagWrite  <= 1'b1;
                     wordWrite <= '1;
                     if (reqReg.write) begin
                        memReqCyc <= 1'b1;
                        state     <= writeAddr;
                     end else begin
                        respCyc <= 1'b1;
                        state   <= respond;
                     end
                  end
               end
            end
            writeAddr: begin
               if (beatOut) begin
                  beatCnt <= '0;
                  state   <= writeData;
               end
            end
            writeData: begin
               if (beatOut) begin
                  beatCnt <= beatCnt + 1'b1;
                  // Core hears back only once the last beat is taken
                  if (beatCnt == '1) begin
                     memReqCyc <= 1'b0;
                     respCyc   <= 1'b1;
                     state     <= respond;
                  end
               end
            end
            respond: begin
               if (respAck) begin
                  respCyc <= 1'b0;
                  state   <= idle;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // Request, line buffer and bus payloads
   always_ff @(posedge rwArbiterCacheBus) begin
      if (state == idle && coreReq.reqCyc) begin
         reqReg <= coreReq;
      end
      if (state == lookup && lookupReady) begin
         respData           <= reqReg.write ? reqReg.wrData : readLine[reqReg.addr.offset];
         lineBuf            <= hitLine;
         memReqWrite        <= hit && reqReg.write;
         memPayload.addr    <= lineAddr;
      end
      if (beatIn) begin
         lineBuf  <= refillLine;
         respData <= refillLine[reqReg.addr.offset];
         if (beatCnt == '1) begin
            // Address beat for a following write-through
            memReqWrite     <= 1'b1;
            memPayload.addr <= lineAddr;
         end
      end
      // Next data word once the current beat is taken
      if ((state == writeAddr || state == writeData) && beatOut) begin
         memPayload.data <= lineBuf[nextBeat];
      end
   end

   assign lookupAddr       = reqReg.addr;
   assign writeTag         = reqReg.addr.tag;
   assign writeLine        = lineBuf;
   assign coreResp.respCyc = respCyc;
   assign coreResp.rdData  = respData;
   assign memReq.reqCyc    = memReqCyc;
   assign memReq.write     = memReqWrite;
   assign memReq.payload   = memPayload;

endmodule

`default_nettype wire

// File: dataCache/tagStore.sv
// Valid bits and tags of the direct-mapped data cache
// Lookup is registered; hit is valid the cycle after lookupAddr is presented
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tagStore (
   input  logic                      rwArbiterCacheBus,
   input  logic                      rstN,
   input  cacheLinePkg::cacheAddrT   lookupAddr,
   output logic                      hit,
   input  logic                      tagWrite,
   input  logic [`DC_INDEX_BITS-1:0] writeIndex,
   input  cacheLinePkg::cacheTagT    writeTag
);
   import cacheLinePkg::*;

   logic [(1 << `DC_INDEX_BITS)-1:0] valid;
   cacheTagT                         tags [1 << `DC_INDEX_BITS];

   // Lookup captured one cycle back
   cacheTagT                         lookTag;
   logic [`DC_INDEX_BITS-1:0]        lookIndex;

   // Cold cache after reset
   always_ff @(posedge rwArbiterCacheBus) begin
      if (!rstN) begin
         valid <= '0;
      end else if (tagWrite) begin
         valid[writeIndex] <= 1'b1;
      end
   end

   always_ff @(posedge rwArbiterCacheBus) begin
      if (tagWrite) begin
         tags[writeIndex] <= writeTag;
      end
      lookTag   <= lookupAddr.tag;
      lookIndex <= lookupAddr.index;
   end

   // Stored entry is checked live, so an install shows up at once
   assign hit = valid[lookIndex] && (tags[lookIndex] == lookTag);

endmodule

`default_nettype wire

// File: dataCache/lineSram.sv
// Line storage of the data cache, one line per index
// Registered read of a full line; writes go word by word under wordWrite
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module lineSram (
   input  logic                      rwArbiterCacheBus,
   input  logic [`DC_INDEX_BITS-1:0] readIndex,
   output cacheLinePkg::cacheLineT   readLine,
   input  logic [`DC_INDEX_BITS-1:0] writeIndex,
   input  cacheLinePkg::cacheLineT   writeLine,
   input  cacheLinePkg::wordMaskT    wordWrite
);
   import cacheLinePkg::*;

   cacheLineT mem [1 << `DC_INDEX_BITS];

   always_ff @(posedge rwArbiterCacheBus) begin
      // Merge writes one word, refill writes all of them
      for (int w = 0; w < $bits(wordMaskT); w++) begin
         if (wordWrite[w]) begin
            mem[writeIndex][w] <= writeLine[w];
         end
      end
      // Old contents on a same-index collision
      readLine <= mem[readIndex];
   end

endmodule

`default_nettype wire

// File: common/cacheBusPkg.sv
// Core-side and memory-side bus payloads of the data cache
// Both sides use a cyc/ack handshake; each struct is one direction of one bus
`default_nettype none

`include "dcache_macros.svh"

package cacheBusPkg;

   // Core request, held until reqAck
   typedef struct packed {
      logic                     reqCyc;
      logic                     write;
      cacheLinePkg::cacheAddrT  addr;
      logic [`DC_WORD_BITS-1:0] wrData;
   } coreReqT;

   // Core response, held until respAck
   typedef struct packed {
      logic                     respCyc;
      logic [`DC_WORD_BITS-1:0] rdData;
   } coreRespT;

   // One memory request word
   // First beat carries the line address, write beats carry raw data
   typedef union packed {
      cacheLinePkg::cacheAddrT  addr;
      logic [`DC_WORD_BITS-1:0] data;
   } memPayloadU;

   // Memory request beat, held until memReqAck
   typedef struct packed {
      logic       reqCyc;
      logic       write;
      memPayloadU payload;
   } memReqT;

   // Refill beat from memory, held until memRespAck
   typedef struct packed {
      logic                     respCyc;
      logic [`DC_WORD_BITS-1:0] rdData;
   } memRespT;

endpackage

`default_nettype wire

// File: common/cacheLinePkg.sv
// Address split, line and tag types, controller states
// Shared by the line store, the tag store and the controller
`default_nettype none

`include "dcache_macros.svh"

package cacheLinePkg;

   // Stored tag of one line
   typedef logic [`DC_TAG_BITS-1:0] cacheTagT;

   // Byte address as the cache sees it, tag in the upper bits
   typedef struct packed {
      cacheTagT                   tag;
      logic [`DC_INDEX_BITS-1:0]  index;
      logic [`DC_OFFSET_BITS-1:0] offset;
      logic [`DC_BYTE_BITS-1:0]   byteOff;
   } cacheAddrT;

   // Whole line, word 0 in the low bits
   typedef logic [(1 << `DC_OFFSET_BITS)-1:0][`DC_WORD_BITS-1:0] cacheLineT;

   // One enable per word of a line
   typedef logic [(1 << `DC_OFFSET_BITS)-1:0] wordMaskT;

   // Controller FSM
   typedef enum logic [2:0] {
      idle,
      lookup,
      refill,
      writeAddr,
      writeData,
      respond
   } ctrlStateT;

endpackage

`default_nettype wire

// File: common/dcache_macros.svh
// Cache geometry sizes shared by the packages and the RTL
// Include wherever a width is needed; the guard makes repeat includes harmless
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Data word and byte address width
`define DC_WORD_BITS 32

// 16 lines
`define DC_INDEX_BITS 4

// 8 words per line
`define DC_OFFSET_BITS 3

// Byte within a word
`define DC_BYTE_BITS 2

// Whatever is left of the address
`define DC_TAG_BITS (`DC_WORD_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS - `DC_BYTE_BITS)

`endif
